// File: rtl/nocPkg.sv
`default_nettype none

package nocPkg;

  // ############################################################
  // Port indices
  localparam int NUM_PORTS = 5;

  localparam int PORT_L = 0;
  localparam int PORT_N = 1;
  localparam int PORT_E = 2;
  localparam int PORT_W = 3;
  localparam int PORT_S = 4;

  // ############################################################
  // Flit format
  localparam int FLIT_ID_W = 3;

  localparam logic [FLIT_ID_W-1:0] FLIT_HEAD = 3'd1;
  localparam logic [FLIT_ID_W-1:0] FLIT_BODY = 3'd2;

  localparam int DEST_W    = 4;
  localparam int LEN_W     = 12;
  localparam int PAYLOAD_W = 16;
  localparam int FLIT_W    = FLIT_ID_W + PAYLOAD_W; // 19 bits

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = 3;

  typedef struct packed
  {
    logic [DEST_W-1:0] dest;
    logic [LEN_W-1:0]  len;   // Grant length in cycles
  } flitHead_t;

  // Header or body view of the same payload word, chosen by the id
  typedef union packed
  {
    flitHead_t            head;
    logic [PAYLOAD_W-1:0] data;
  } flitPayload_u;

  typedef struct packed
  {
    logic [FLIT_ID_W-1:0] id;
    flitPayload_u         payload;
  } flit_t;

endpackage

`default_nettype wire

// File: rtl/flitFifo.sv
`timescale 1ns/1ps
`default_nettype none

module flitFifo
(
  input  wire                clk,
  input  wire                rst,
  input  wire nocPkg::flit_t inFlit,
  input  wire                push,
  input  wire                pop,
  output nocPkg::flit_t      headFlit,
  output logic               notEmpty,
  output logic               ready
);

  logic [nocPkg::FLIT_W-1:0]  mem [nocPkg::FIFO_DEPTH];
  logic [nocPkg::FIFO_AW-1:0] wrPtr;
  logic [nocPkg::FIFO_AW-1:0] rdPtr;
  logic [nocPkg::FIFO_AW:0]   count;
  logic                       doPush;
  logic                       doPop;

  assign notEmpty = (count != '0);
  assign ready    = (count != (nocPkg::FIFO_AW + 1)'(nocPkg::FIFO_DEPTH));

  assign doPush = push & ready;    // Dropped when full
  assign doPop  = pop & notEmpty;

  assign headFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doPush)
      mem[wrPtr] <= inFlit;
  end

  // Pointers wrap naturally at the depth
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= wrPtr + 1'b1;
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/hopTimer.sv
`timescale 1ns/1ps
`default_nettype none

module hopTimer
(
  input  wire                clk,
  input  wire                rst,
  input  wire nocPkg::flit_t headFlit,
  input  wire                run,
  output logic               timesUp
);

  logic [nocPkg::LEN_W-1:0] limit;
  logic [nocPkg::LEN_W-1:0] count;
  logic [nocPkg::LEN_W-1:0] lastCount;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (headFlit.id == nocPkg::FLIT_HEAD)
        limit <= headFlit.payload.head.len;   // Kept until the next header
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // Zero length counts as one cycle
  assign lastCount = (limit == '0) ? '0 : limit - 1'b1;
  assign timesUp   = (count == lastCount);

endmodule

`default_nettype wire

// File: rtl/portArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module portArbiter
(
  input  wire                          clk,
  input  wire                          rst,
  input  wire [nocPkg::NUM_PORTS-1:0]  req,
  input  wire nocPkg::flit_t           headFlit0,
  input  wire nocPkg::flit_t           headFlit1,
  input  wire nocPkg::flit_t           headFlit2,
  input  wire nocPkg::flit_t           headFlit3,
  input  wire nocPkg::flit_t           headFlit4,
  output logic [nocPkg::NUM_PORTS-1:0] grant
);

  nocPkg::flit_t                heads [nocPkg::NUM_PORTS];
  logic [nocPkg::NUM_PORTS:0]   state;       // Bit 0 idle, bit p+1 port p
  logic [nocPkg::NUM_PORTS:0]   nextState;
  logic [nocPkg::NUM_PORTS-1:0] run;
  logic [nocPkg::NUM_PORTS-1:0] timesUp;
  logic [nocPkg::NUM_PORTS-1:0] pick;

  // First requester found walking span ports from start, wrapping at S
  function automatic logic [nocPkg::NUM_PORTS-1:0] firstReq
  (
    input logic [nocPkg::NUM_PORTS-1:0] r,
    input int                           start,
    input int                           span
  );
    logic [nocPkg::NUM_PORTS-1:0] sel;
    int                           idx;
    sel = '0;
    for (int k = 0; k < span; k++)
    begin
      idx = (start + k) % nocPkg::NUM_PORTS;
      if (r[idx] && (sel == '0))
        sel[idx] = 1'b1;
    end
    return sel;
  endfunction

  assign heads[nocPkg::PORT_L] = headFlit0;
  assign heads[nocPkg::PORT_N] = headFlit1;
  assign heads[nocPkg::PORT_E] = headFlit2;
  assign heads[nocPkg::PORT_W] = headFlit3;
  assign heads[nocPkg::PORT_S] = headFlit4;

  // ############################################################
  // Hop timers, one per input
  for (genvar p = 0; p < nocPkg::NUM_PORTS; p++)
  begin : gTimer
    hopTimer uTimer
    (
      .clk      (clk),
      .rst      (rst),
      .headFlit (heads[p]),
      .run      (run[p]),
      .timesUp  (timesUp[p])
    );
  end

  // ############################################################
  // State machine
  always_ff @(posedge clk)
  begin
    if (rst)
      state <= (nocPkg::NUM_PORTS + 1)'(1);   // Idle
    else
      state <= nextState;
  end

  always_comb
  begin
    pick = '0;
    run  = '0;
    if (state[0])
      pick = firstReq(req, nocPkg::PORT_L, nocPkg::NUM_PORTS);   // Fixed priority
    for (int p = 0; p < nocPkg::NUM_PORTS; p++)
    begin
      if (state[p + 1])
      begin
        if (req[p] && !timesUp[p])
        begin
          run[p]  = 1'b1;
          pick    = '0;
          pick[p] = 1'b1;   // Holder keeps the channel
        end
        else
          // Ring order after the holder, holder excluded
          pick = firstReq(req, p + 1, nocPkg::NUM_PORTS - 1);
      end
    end
    nextState = {pick, (pick == '0)};
  end

  assign grant = state[nocPkg::NUM_PORTS:1];

endmodule

`default_nettype wire

// File: rtl/linkDriver.sv
`timescale 1ns/1ps
`default_nettype none

module linkDriver
(
  input  wire                          clk,
  input  wire                          rst,
  input  wire [nocPkg::NUM_PORTS-1:0]  grant,
  input  wire [nocPkg::NUM_PORTS-1:0]  notEmpty,
  input  wire nocPkg::flit_t           headFlit0,
  input  wire nocPkg::flit_t           headFlit1,
  input  wire nocPkg::flit_t           headFlit2,
  input  wire nocPkg::flit_t           headFlit3,
  input  wire nocPkg::flit_t           headFlit4,
  output logic [nocPkg::NUM_PORTS-1:0] pop,
  output nocPkg::flit_t                outFlit,
  output logic                         outValid
);

  nocPkg::flit_t heads [nocPkg::NUM_PORTS];
  nocPkg::flit_t selFlit;

  assign heads[nocPkg::PORT_L] = headFlit0;
  assign heads[nocPkg::PORT_N] = headFlit1;
  assign heads[nocPkg::PORT_E] = headFlit2;
  assign heads[nocPkg::PORT_W] = headFlit3;
  assign heads[nocPkg::PORT_S] = headFlit4;

  assign pop = grant & notEmpty;   // Empty granted FIFO sends nothing

  // Grant is one-hot
  always_comb
  begin
    selFlit = '0;
    for (int p = 0; p < nocPkg::NUM_PORTS; p++)
    begin
      if (grant[p])
        selFlit = heads[p];
    end
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
      outFlit <= selFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |pop;   // One pulse per flit
  end

endmodule

`default_nettype wire

// File: rtl/outputPort.sv
`timescale 1ns/1ps
`default_nettype none

module outputPort
(
  input  wire                clk,
  input  wire                rst,
  input  wire nocPkg::flit_t inFlitL,
  input  wire nocPkg::flit_t inFlitN,
  input  wire nocPkg::flit_t inFlitE,
  input  wire nocPkg::flit_t inFlitW,
  input  wire nocPkg::flit_t inFlitS,
  input  wire                inValidL,
  input  wire                inValidN,
  input  wire                inValidE,
  input  wire                inValidW,
  input  wire                inValidS,
  output logic               inReadyL,
  output logic               inReadyN,
  output logic               inReadyE,
  output logic               inReadyW,
  output logic               inReadyS,
  output nocPkg::flit_t      outFlit,
  output logic               outValid
);

  nocPkg::flit_t                headFlit0;
  nocPkg::flit_t                headFlit1;
  nocPkg::flit_t                headFlit2;
  nocPkg::flit_t                headFlit3;
  nocPkg::flit_t                headFlit4;
  logic [nocPkg::NUM_PORTS-1:0] notEmpty;   // Doubles as the request
  logic [nocPkg::NUM_PORTS-1:0] grant;
  logic [nocPkg::NUM_PORTS-1:0] pop;

  // ############################################################
  // Input FIFOs
  flitFifo uFifoL (.clk(clk), .rst(rst), .inFlit(inFlitL), .push(inValidL),
                   .pop(pop[nocPkg::PORT_L]), .headFlit(headFlit0),
                   .notEmpty(notEmpty[nocPkg::PORT_L]), .ready(inReadyL));

  flitFifo uFifoN (.clk(clk), .rst(rst), .inFlit(inFlitN), .push(inValidN),
                   .pop(pop[nocPkg::PORT_N]), .headFlit(headFlit1),
                   .notEmpty(notEmpty[nocPkg::PORT_N]), .ready(inReadyN));

  flitFifo uFifoE (.clk(clk), .rst(rst), .inFlit(inFlitE), .push(inValidE),
                   .pop(pop[nocPkg::PORT_E]), .headFlit(headFlit2),
                   .notEmpty(notEmpty[nocPkg::PORT_E]), .ready(inReadyE));

  flitFifo uFifoW (.clk(clk), .rst(rst), .inFlit(inFlitW), .push(inValidW),
                   .pop(pop[nocPkg::PORT_W]), .headFlit(headFlit3),
                   .notEmpty(notEmpty[nocPkg::PORT_W]), .ready(inReadyW));

  flitFifo uFifoS (.clk(clk), .rst(rst), .inFlit(inFlitS), .push(inValidS),
                   .pop(pop[nocPkg::PORT_S]), .headFlit(headFlit4),
                   .notEmpty(notEmpty[nocPkg::PORT_S]), .ready(inReadyS));

  // ############################################################
  // Arbitration and output link
  portArbiter uArbiter
  (
    .clk       (clk),
    .rst       (rst),
    .req       (notEmpty),
    .headFlit0 (headFlit0),
    .headFlit1 (headFlit1),
    .headFlit2 (headFlit2),
    .headFlit3 (headFlit3),
    .headFlit4 (headFlit4),
    .grant     (grant)
  );

  linkDriver uLink
  (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .notEmpty  (notEmpty),
    .headFlit0 (headFlit0),
    .headFlit1 (headFlit1),
    .headFlit2 (headFlit2),
    .headFlit3 (headFlit3),
    .headFlit4 (headFlit4),
    .pop       (pop),
    .outFlit   (outFlit),
    .outValid  (outValid)
  );

endmodule

`default_nettype wire

// File: tests/portArbiter_chk.sv
`timescale 1ns/1ps
`default_nettype none

module portArbiter_chk
(
  input wire                         clk,
  input wire                         rst,
  input wire [nocPkg::NUM_PORTS-1:0] req,
  input wire [nocPkg::NUM_PORTS:0]   state,
  input wire [nocPkg::NUM_PORTS:0]   nextState,
  input wire [nocPkg::NUM_PORTS-1:0] run
);

  int failCount = 0;   // Read by the testbench at the end

  aOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
  else
  begin
    failCount++;
    $error("arbiter state %b is not one-hot", state);
  end

  aTimerOwn: assert property (@(posedge clk) disable iff (rst)
    (run & ~state[nocPkg::NUM_PORTS:1]) == '0)
  else
  begin
    failCount++;
    $error("hop timer %b runs outside its grant state %b", run, state);
  end

  // Next holder must be requesting
  aGrantReq: assert property (@(posedge clk) disable iff (rst)
    (nextState[nocPkg::NUM_PORTS:1] & ~req) == '0)
  else
  begin
    failCount++;
    $error("grant %b given without request %b", nextState, req);
  end

endmodule

`default_nettype wire

// File: tests/tb_outputPort.sv
`timescale 1ns/1ps
`default_nettype none

module tb_outputPort;

  localparam int MAX_FLITS       = 16;
  localparam int TOTAL_FLITS     = 4 + 12 + 12 + 7 + 25;   // Flits over all five tests
  localparam int WATCHDOG_CYCLES = TOTAL_FLITS * 20;

  logic                         clk;
  logic                         rst;
  nocPkg::flit_t                inFlit [nocPkg::NUM_PORTS];
  logic [nocPkg::NUM_PORTS-1:0] inValid;
  wire  [nocPkg::NUM_PORTS-1:0] inReady;
  nocPkg::flit_t                outFlit;
  logic                         outValid;

  nocPkg::flit_t stim [nocPkg::NUM_PORTS][MAX_FLITS];
  int            stimLen [nocPkg::NUM_PORTS];
  int            stimStart [nocPkg::NUM_PORTS];   // Cycle of the first push
  logic          readyAtPush [nocPkg::NUM_PORTS][MAX_FLITS];
  nocPkg::flit_t expQ [$];
  nocPkg::flit_t expFlit;
  int            errorCount = 0;
  int            chkFails;
  integer        seed = 32'h9fcd;

  outputPort u_dut
  (
    .clk      (clk),
    .rst      (rst),
    .inFlitL  (inFlit[nocPkg::PORT_L]),
    .inFlitN  (inFlit[nocPkg::PORT_N]),
    .inFlitE  (inFlit[nocPkg::PORT_E]),
    .inFlitW  (inFlit[nocPkg::PORT_W]),
    .inFlitS  (inFlit[nocPkg::PORT_S]),
    .inValidL (inValid[nocPkg::PORT_L]),
    .inValidN (inValid[nocPkg::PORT_N]),
    .inValidE (inValid[nocPkg::PORT_E]),
    .inValidW (inValid[nocPkg::PORT_W]),
    .inValidS (inValid[nocPkg::PORT_S]),
    .inReadyL (inReady[nocPkg::PORT_L]),
    .inReadyN (inReady[nocPkg::PORT_N]),
    .inReadyE (inReady[nocPkg::PORT_E]),
    .inReadyW (inReady[nocPkg::PORT_W]),
    .inReadyS (inReady[nocPkg::PORT_S]),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  bind portArbiter portArbiter_chk uChk
  (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .state     (state),
    .nextState (nextState),
    .run       (run)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ############################################################
  // Stimulus helpers
  task automatic clearStim();
    for (int p = 0; p < nocPkg::NUM_PORTS; p++)
    begin
      stimLen[p]   = 0;
      stimStart[p] = 0;
    end
  endtask

  task automatic makePacket(input int port, input int start, input int nFlits, input int len);
    nocPkg::flit_t f;
    logic [31:0]   r;
    stimStart[port] = start;
    stimLen[port]   = nFlits;
    for (int i = 0; i < nFlits; i++)
    begin
      f = '0;
      r = $random(seed);
      if (i == 0)
      begin
        f.id                = nocPkg::FLIT_HEAD;
        f.payload.head.dest = r[3:0];
        f.payload.head.len  = len[11:0];
      end
      else
      begin
        f.id           = nocPkg::FLIT_BODY;
        f.payload.data = r[15:0];
      end
      stim[port][i] = f;
    end
  endtask

  task automatic expectFlits(input int port, input int first, input int count);
    for (int i = first; i < first + count; i++)
      expQ.push_back(stim[port][i]);
  endtask

  // One push per port and cycle, as scheduled in stim
  task automatic driveInputs();
    int cyc;
    int idx;
    bit busy;
    cyc  = 0;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge clk);
      busy = 1'b0;
      for (int p = 0; p < nocPkg::NUM_PORTS; p++)
      begin
        idx        = cyc - stimStart[p];
        inValid[p] = 1'b0;
        if (idx >= 0 && idx < stimLen[p])
        begin
          inFlit[p]           = stim[p][idx];
          inValid[p]          = 1'b1;
          readyAtPush[p][idx] = inReady[p];
        end
        if (idx < stimLen[p] - 1)
          busy = 1'b1;
      end
      cyc++;
    end
    @(negedge clk);
    inValid = '0;
  endtask

  task automatic waitDrain(input int limit);
    int n;
    n = 0;
    while (expQ.size() != 0 && n < limit)
    begin
      @(posedge clk);
      n++;
    end
    assert (expQ.size() == 0)
    else
    begin
      $display("timed out with %0d flits still expected", expQ.size());
      errorCount++;
    end
    expQ.delete();
    repeat (4) @(posedge clk);   // Let the arbiter go idle
    clearStim();
  endtask

  // ############################################################
  // Scoreboard monitor
  always @(negedge clk)
  begin
    if (!rst && outValid)
    begin
      assert (expQ.size() != 0)
      else
      begin
        $display("flit %h arrived on outFlit while none was expected", outFlit);
        errorCount++;
      end
      if (expQ.size() != 0)
      begin
        expFlit = expQ.pop_front();
        assert (outFlit == expFlit)
        else
        begin
          $display("error: outFlit %h expected %h", outFlit, expFlit);
          errorCount++;
        end
      end
    end
  end

  // ############################################################
  // Directed tests
  task automatic testSinglePacket();
    assert (outValid == 1'b0)
    else
    begin
      $display("error: outValid %h expected %h", outValid, 1'b0);
      errorCount++;
    end
    assert (inReady == 5'h1f)
    else
    begin
      $display("error: inReady %h expected %h", inReady, 5'h1f);
      errorCount++;
    end
    makePacket(nocPkg::PORT_L, 0, 4, 4);
    expectFlits(nocPkg::PORT_L, 0, 4);
    driveInputs();
    waitDrain(20 * 4);
  endtask

  task automatic testFixedPriority();
    makePacket(nocPkg::PORT_L, 0, 2, 2);
    makePacket(nocPkg::PORT_N, 0, 3, 3);
    makePacket(nocPkg::PORT_E, 0, 2, 2);
    makePacket(nocPkg::PORT_W, 0, 3, 3);
    makePacket(nocPkg::PORT_S, 0, 2, 2);
    for (int p = 0; p < nocPkg::NUM_PORTS; p++)
      expectFlits(p, 0, stimLen[p]);
    driveInputs();
    waitDrain(20 * 12);
  endtask

  task automatic testRingOrder();
    makePacket(nocPkg::PORT_W, 0, 4, 4);   // W wins alone from idle
    makePacket(nocPkg::PORT_S, 1, 2, 2);
    makePacket(nocPkg::PORT_L, 1, 2, 2);
    makePacket(nocPkg::PORT_N, 1, 2, 2);
    makePacket(nocPkg::PORT_E, 1, 2, 2);
    expectFlits(nocPkg::PORT_W, 0, 4);
    expectFlits(nocPkg::PORT_S, 0, 2);
    expectFlits(nocPkg::PORT_L, 0, 2);
    expectFlits(nocPkg::PORT_N, 0, 2);
    expectFlits(nocPkg::PORT_E, 0, 2);
    driveInputs();
    waitDrain(20 * 12);
  endtask

  task automatic testTimeoutSplit();
    makePacket(nocPkg::PORT_L, 0, 5, 2);   // Limit 2 over five flits
    makePacket(nocPkg::PORT_N, 0, 2, 2);
    expectFlits(nocPkg::PORT_L, 0, 2);
    expectFlits(nocPkg::PORT_N, 0, 2);
    expectFlits(nocPkg::PORT_L, 2, 3);
    driveInputs();
    waitDrain(20 * 7);
  endtask

  task automatic testBackPressure();
    logic expReady;
    makePacket(nocPkg::PORT_N, 0, 16, 16);   // Keeps S waiting
    makePacket(nocPkg::PORT_S, 1, 9, 8);
    expectFlits(nocPkg::PORT_N, 0, 16);
    expectFlits(nocPkg::PORT_S, 0, nocPkg::FIFO_DEPTH);   // Ninth push is lost
    driveInputs();
    for (int i = 0; i < 9; i++)
    begin
      expReady = (i < nocPkg::FIFO_DEPTH);
      assert (readyAtPush[nocPkg::PORT_S][i] == expReady)
      else
      begin
        $display("error: inReadyS %h expected %h at push %0d",
                 readyAtPush[nocPkg::PORT_S][i], expReady, i);
        errorCount++;
      end
    end
    waitDrain(20 * 25);
  endtask

  // ############################################################
  // Main sequence
  initial
  begin
    rst     = 1'b1;
    inValid = '0;
    for (int p = 0; p < nocPkg::NUM_PORTS; p++)
      inFlit[p] = '0;
    clearStim();
    repeat (5) @(negedge clk);
    rst = 1'b0;
    testSinglePacket();
    testFixedPriority();
    testRingOrder();
    testTimeoutSplit();
    testBackPressure();
    chkFails = u_dut.uArbiter.uChk.failCount;
    $display("error count: %0d scoreboard, %0d arbiter assertions", errorCount, chkFails);
    if (errorCount == 0 && chkFails == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
rtl/nocPkg.sv
rtl/flitFifo.sv
rtl/hopTimer.sv
rtl/portArbiter.sv
rtl/linkDriver.sv
rtl/outputPort.sv
tests/portArbiter_chk.sv
tests/tb_outputPort.sv
